/* logic/board_defines.svh */
/*
 * Board-level constants for the host-bus core: address spaces, register
 * offsets, field widths and the watchdog tick. Include wherever a macro is used.
 */
`ifndef BOARD_DEFINES_SVH
`define BOARD_DEFINES_SVH

// ----------------------------------------
// register bus widths
// ----------------------------------------
`define REG_ADDR_W      16              // register address bits
`define REG_DATA_W      32              // quadlet register word
`define BOARD_ID_W      4               // rotary switch
`define WDOG_PERIOD_W   16              // low half of the written word

// ----------------------------------------
// address map
// ----------------------------------------
`define ADDR_MAIN       4'h0            // addr[15:12] of board registers
`define REG_STATUS      4'd0            // board status
`define REG_WDOG        4'd3            // watchdog period
`define REG_IPADDR      4'd11           // ip address
`define IP_RESET        32'hFFFF_FFFF   // unassigned ip after reset

// watchdog period unit, kept small so simulation stays short
`define WDOG_TICK       16

// link request fields
`define LREQ_TYPE_W     3
`define LREQ_DATA_W     12

`endif

/* logic/regbus_pkg.sv */
/*
 * Types carried on the internal register read/write bus and by the
 * board register block. Modules name these in ports as regbus_pkg::<type>.
 */
`include "board_defines.svh"

package regbus_pkg;

    // register address, space code in [15:12], offset in [3:0]
    typedef logic [`REG_ADDR_W-1:0]    reg_addr_t;

    // one quadlet of register data
    typedef logic [`REG_DATA_W-1:0]    reg_data_t;

    typedef logic [`BOARD_ID_W-1:0]    board_id_t;     // rotary switch number

    // watchdog period, in units of WDOG_TICK cycles
    typedef logic [`WDOG_PERIOD_W-1:0] wdog_period_t;

endpackage

/* logic/phylink_pkg.sv */
/*
 * Types for the PHY link request: request type, payload and the
 * serializer state machine encoding.
 */
`include "board_defines.svh"

package phylink_pkg;

    typedef logic [`LREQ_TYPE_W-1:0] lreq_type_t;      // request type, msb first on lreq
    typedef logic [`LREQ_DATA_W-1:0] lreq_data_t;      // request payload

    typedef enum logic [1:0] {
        IDLE,           // lreq low, waiting for a trigger
        SEND_TYPE,      // start bit then type bits
        SEND_DATA,      // payload bits
        STOP            // last data bit, stop bit follows
    } lreq_state_e;

endpackage

/* logic/host_bus_mux.sv */
/*
 * Arbitrates the FireWire and Ethernet hosts onto the single internal
 * register bus. Purely combinational; eth wins whenever it requests.
 */
`timescale 1ns/1ps

module host_bus_mux (
    input  logic                    fw_req_read_bus,    // fw wants the read bus
    input  regbus_pkg::reg_addr_t   fw_reg_raddr,
    input  logic                    fw_req_write_bus,   // fw wants the write bus
    input  regbus_pkg::reg_addr_t   fw_reg_waddr,
    input  regbus_pkg::reg_data_t   fw_reg_wdata,
    input  logic                    fw_reg_wen,
    input  logic                    fw_lreq_trig,
    input  phylink_pkg::lreq_type_t fw_lreq_type,
    input  logic                    eth_req_read_bus,   // eth wants the read bus
    input  regbus_pkg::reg_addr_t   eth_reg_raddr,
    input  logic                    eth_req_write_bus,  // eth wants the write bus
    input  regbus_pkg::reg_addr_t   eth_reg_waddr,
    input  regbus_pkg::reg_data_t   eth_reg_wdata,
    input  logic                    eth_reg_wen,
    input  logic                    eth_lreq_trig,
    input  phylink_pkg::lreq_type_t eth_lreq_type,
    output regbus_pkg::reg_addr_t   reg_raddr,          // muxed read address
    output regbus_pkg::reg_addr_t   reg_waddr,
    output regbus_pkg::reg_data_t   reg_wdata,
    output logic                    reg_wen,
    output logic                    lreq_trig,          // either host triggers
    output phylink_pkg::lreq_type_t lreq_type
);

    // read bus, parked at address 0 when nobody asks for it
    assign reg_raddr = eth_req_read_bus ? eth_reg_raddr :
                       fw_req_read_bus  ? fw_reg_raddr  : '0;

    // write bus, fw strobe only counts while fw holds the bus
    assign reg_waddr = eth_req_write_bus ? eth_reg_waddr : fw_reg_waddr;
    assign reg_wdata = eth_req_write_bus ? eth_reg_wdata : fw_reg_wdata;
    assign reg_wen   = eth_req_write_bus ? eth_reg_wen : (fw_req_write_bus & fw_reg_wen);

    // phy request, eth type wins on a simultaneous trigger
    assign lreq_trig = eth_lreq_trig | fw_lreq_trig;
    assign lreq_type = eth_lreq_trig ? eth_lreq_type : fw_lreq_type;

endmodule

/* logic/board_regs.sv */
/*
 * Main-space board registers: status, IP address and watchdog period.
 * Decodes main-space writes for the watchdog and routes read data,
 * falling back to the external board data for anything not held here.
 */
`timescale 1ns/1ps
`include "board_defines.svh"

module board_regs (
    input  logic                     sysclk,
    input  logic                     rst_n,
    input  regbus_pkg::reg_addr_t    reg_raddr,
    input  regbus_pkg::reg_addr_t    reg_waddr,
    input  regbus_pkg::reg_data_t    reg_wdata,
    input  logic                     reg_wen,
    input  regbus_pkg::reg_data_t    reg_rdata_ext,  // external board registers
    input  regbus_pkg::board_id_t    board_id,
    input  logic                     wdog_timeout,
    output regbus_pkg::reg_data_t    reg_rdata,
    output regbus_pkg::wdog_period_t wdog_period,    // period in ticks, 0 = off
    output logic                     wdog_kick,      // any main-space write
    output logic                     wdog_period_wr  // write to REG_WDOG
);
    import regbus_pkg::*;

    logic      raddr_main;     // read hits board register space
    logic      waddr_main;     // write hits board register space
    logic      ip_wr;
    reg_data_t ip_address;

    // ----------------------------------------
    // address decode
    // ----------------------------------------
    assign raddr_main = (reg_raddr[15:12] == `ADDR_MAIN) && (reg_raddr[7:4] == 4'd0);
    assign waddr_main = (reg_waddr[15:12] == `ADDR_MAIN) && (reg_waddr[7:4] == 4'd0);

    assign wdog_kick      = reg_wen & waddr_main;
    assign wdog_period_wr = wdog_kick & (reg_waddr[3:0] == `REG_WDOG);
    assign ip_wr          = wdog_kick & (reg_waddr[3:0] == `REG_IPADDR);

    // ----------------------------------------
    // writable registers
    // ----------------------------------------
    always_ff @(posedge sysclk or negedge rst_n) begin
        if (!rst_n) begin
            ip_address  <= `IP_RESET;               // no address until host sets one
            wdog_period <= '0;                      // watchdog off
        end else begin
            if (ip_wr)
                ip_address <= reg_wdata;
            if (wdog_period_wr)
                wdog_period <= reg_wdata[`WDOG_PERIOD_W-1:0];
        end
    end

    // ----------------------------------------
    // read data routing, zero latency
    // ----------------------------------------
    always_comb begin
        reg_rdata = reg_rdata_ext;                  // other spaces and unused offsets
        if (raddr_main) begin
            case (reg_raddr[3:0])
                `REG_STATUS: reg_rdata = {4'd0, board_id, 23'd0, wdog_timeout};
                `REG_IPADDR: reg_rdata = ip_address;
                `REG_WDOG:   reg_rdata = reg_data_t'(wdog_period);   // zero-extended
                default:     reg_rdata = reg_rdata_ext;
            endcase
        end
    end

endmodule

/* logic/wdog_timer.sv */
/*
 * Host watchdog. Counts sysclk cycles since the last main-space write
 * and raises a sticky timeout once period * WDOG_TICK cycles have passed.
 */
`timescale 1ns/1ps
`include "board_defines.svh"

module wdog_timer (
    input  logic                     sysclk,
    input  logic                     rst_n,
    input  regbus_pkg::wdog_period_t wdog_period,     // 0 disables
    input  logic                     wdog_kick,       // restart count
    input  logic                     wdog_period_wr,  // new period, restart count
    input  logic                     wdog_clear,      // drop the timeout flag
    output logic                     wdog_timeout
);
    import regbus_pkg::*;

    // wide enough for the largest period scaled by the tick
    localparam int CNT_W = $bits(wdog_period_t) + $clog2(`WDOG_TICK);

    logic [CNT_W-1:0] cycle_cnt;    // cycles since last kick
    logic [CNT_W-1:0] limit;        // period in cycles
    logic             expired;

    assign limit   = CNT_W'(wdog_period) * CNT_W'(`WDOG_TICK);
    assign expired = (wdog_period != '0) && (cycle_cnt == limit);

    // saturating cycle counter
    always_ff @(posedge sysclk or negedge rst_n) begin
        if (!rst_n)
            cycle_cnt <= '0;
        else if (wdog_kick || wdog_period_wr)
            cycle_cnt <= '0;
        else if (cycle_cnt < limit)
            cycle_cnt <= cycle_cnt + 1'b1;          // holds at limit
    end

    // sticky flag, a kick alone never clears it
    always_ff @(posedge sysclk or negedge rst_n) begin
        if (!rst_n)
            wdog_timeout <= 1'b0;
        else if (wdog_clear || (wdog_period == '0))
            wdog_timeout <= 1'b0;                   // host ack or watchdog disabled
        else if (expired)
            wdog_timeout <= 1'b1;
    end

endmodule

/* logic/phy_request.sv */
/*
 * Serializes a link request onto lreq: start bit, 3 type bits and
 * 12 data bits msb first, then a stop bit. One bit per sysclk; a trigger
 * seen while a frame is going out is dropped.
 */
`timescale 1ns/1ps

module phy_request (
    input  logic                    sysclk,
    input  logic                    rst_n,
    input  logic                    trigger,    // single-cycle request
    input  phylink_pkg::lreq_type_t rtype,
    input  phylink_pkg::lreq_data_t data,
    output logic                    lreq        // serial line to the phy
);
    import phylink_pkg::*;

    localparam int TYPE_W = $bits(lreq_type_t);
    localparam int DATA_W = $bits(lreq_data_t);
    localparam int SHR_W  = TYPE_W + DATA_W;

    lreq_state_e      state;
    logic [3:0]       bit_idx;      // bits left in the current field
    logic [SHR_W-1:0] shreg;        // {type, data}, shifted out msb first

    always_ff @(posedge sysclk or negedge rst_n) begin
        if (!rst_n) begin
            state   <= IDLE;
            lreq    <= 1'b0;
            bit_idx <= '0;
        end else begin
            case (state)
                IDLE: begin
                    lreq <= 1'b0;                   // doubles as the stop bit
                    if (trigger) begin
                        lreq    <= 1'b1;            // start bit next cycle
                        bit_idx <= 4'(TYPE_W - 1);
                        state   <= SEND_TYPE;
                    end
                end
                SEND_TYPE: begin
                    lreq <= shreg[SHR_W-1];
                    if (bit_idx == '0) begin
                        bit_idx <= 4'(DATA_W - 1);
                        state   <= SEND_DATA;
                    end else begin
                        bit_idx <= bit_idx - 1'b1;
                    end
                end
                SEND_DATA: begin
                    lreq <= shreg[SHR_W-1];
                    if (bit_idx == '0)
                        state <= STOP;
                    else
                        bit_idx <= bit_idx - 1'b1;
                end
                STOP: begin
                    lreq  <= 1'b0;                  // stop bit
                    state <= IDLE;
                end
                default: state <= IDLE;
            endcase
        end
    end

    // payload shifter, loaded only when idle
    always_ff @(posedge sysclk) begin
        if (state == IDLE) begin
            if (trigger)
                shreg <= {rtype, data};
        end else begin
            shreg <= {shreg[SHR_W-2:0], 1'b0};
        end
    end

endmodule

/* logic/fpga_board_core.sv */
/*
 * Host-bus core of the FireWire/Ethernet controller board. Muxes the two
 * hosts onto one register bus, serves the board registers, runs the host
 * watchdog and sends PHY link requests on lreq.
 */
`timescale 1ns/1ps
`include "board_defines.svh"

module fpga_board_core (
    input  logic                     sysclk,
    input  logic                     rst_n,
    // firewire host
    input  logic                     fw_req_read_bus,
    input  regbus_pkg::reg_addr_t    fw_reg_raddr,
    input  logic                     fw_req_write_bus,
    input  regbus_pkg::reg_addr_t    fw_reg_waddr,
    input  regbus_pkg::reg_data_t    fw_reg_wdata,
    input  logic                     fw_reg_wen,
    input  logic                     fw_lreq_trig,
    input  phylink_pkg::lreq_type_t  fw_lreq_type,
    // ethernet host
    input  logic                     eth_req_read_bus,
    input  regbus_pkg::reg_addr_t    eth_reg_raddr,
    input  logic                     eth_req_write_bus,
    input  regbus_pkg::reg_addr_t    eth_reg_waddr,
    input  regbus_pkg::reg_data_t    eth_reg_wdata,
    input  logic                     eth_reg_wen,
    input  logic                     eth_lreq_trig,
    input  phylink_pkg::lreq_type_t  eth_lreq_type,
    // board side
    input  regbus_pkg::board_id_t    board_id,
    input  regbus_pkg::reg_data_t    reg_rdata_ext,
    input  logic                     wdog_clear,
    output regbus_pkg::reg_addr_t    reg_raddr,
    output regbus_pkg::reg_data_t    reg_rdata,
    output regbus_pkg::reg_addr_t    reg_waddr,
    output regbus_pkg::reg_data_t    reg_wdata,
    output logic                     reg_wen,
    output logic                     lreq,
    output logic                     wdog_timeout
);
    import regbus_pkg::*;
    import phylink_pkg::*;

    logic         lreq_trig;        // merged trigger
    lreq_type_t   lreq_type;
    wdog_period_t wdog_period;
    logic         wdog_kick;
    logic         wdog_period_wr;

    host_bus_mux i_host_bus_mux (.*);

    board_regs i_board_regs (.*);

    wdog_timer i_wdog_timer (.*);

    // payload rides on the low bits of the write data
    phy_request i_phy_request (
        .sysclk  (sysclk),
        .rst_n   (rst_n),
        .trigger (lreq_trig),
        .rtype   (lreq_type),
        .data    (reg_wdata[`LREQ_DATA_W-1:0]),
        .lreq    (lreq)
    );

endmodule

/* test/fpga_board_core_sva.sv */
/*
 * Concurrent checks on the lreq serializer and the sticky watchdog flag.
 * Bound into every fpga_board_core instance by the bind at the bottom.
 */
`timescale 1ns/1ps

module fpga_board_core_sva (
    input logic                     sysclk,
    input logic                     rst_n,
    input logic                     lreq,
    input logic                     lreq_trig,       // merged host trigger
    input phylink_pkg::lreq_state_e state,
    input logic                     wdog_timeout,
    input logic                     wdog_clear,
    input regbus_pkg::wdog_period_t wdog_period
);
    import phylink_pkg::*;

    // quiet line while idle
    assert property (@(posedge sysclk) disable iff (!rst_n) (state == IDLE) |-> !lreq)
        else $error("lreq high while the request machine is idle");

    // start bit right after an accepted trigger
    assert property (@(posedge sysclk) disable iff (!rst_n) (state == IDLE && lreq_trig) |=> lreq)
        else $error("no start bit after a trigger in idle");

    // sticky until cleared or disabled
    assert property (@(posedge sysclk) disable iff (!rst_n)
        (wdog_timeout && !wdog_clear && wdog_period != '0) |=> wdog_timeout)
        else $error("wdog_timeout dropped without a clear");

endmodule

bind fpga_board_core fpga_board_core_sva i_fpga_board_core_sva (
    .sysclk       (sysclk),
    .rst_n        (rst_n),
    .lreq         (lreq),
    .lreq_trig    (lreq_trig),
    .state        (i_phy_request.state),
    .wdog_timeout (wdog_timeout),
    .wdog_clear   (wdog_clear),
    .wdog_period  (wdog_period)
);

/* test/tb_fpga_board_core.sv */
/*
 * Testbench for the host-bus core. Steps through test/stim_input.txt one
 * operation per line (write, read, link request, watchdog) and checks the
 * read data, the lreq frame and the watchdog flag. Run from the project root.
 */
`timescale 1ns/1ps
`include "board_defines.svh"

module tb_fpga_board_core;
    import regbus_pkg::*;
    import phylink_pkg::*;

    localparam board_id_t BOARD_NUM = 4'h9;     // rotary switch seen by the DUT

    typedef struct packed {
        logic [3:0] op;                         // 1 wr, 2 rd, 3 lreq, 4 wdog, f end
        logic [3:0] host;                       // 0 fw, 1 eth, 2 both
        reg_addr_t  addr;
        reg_data_t  data;                       // write data, ext read data or period
        reg_data_t  exp;
    } stim_t;

    logic       sysclk = 1'b0;
    logic       rst_n;
    logic       fw_req_read_bus, fw_req_write_bus, fw_reg_wen, fw_lreq_trig;
    logic       eth_req_read_bus, eth_req_write_bus, eth_reg_wen, eth_lreq_trig;
    reg_addr_t  fw_reg_raddr, fw_reg_waddr, eth_reg_raddr, eth_reg_waddr;
    reg_data_t  fw_reg_wdata, eth_reg_wdata;
    lreq_type_t fw_lreq_type, eth_lreq_type;
    board_id_t  board_id;
    reg_data_t  reg_rdata_ext;
    logic       wdog_clear;
    reg_addr_t  reg_raddr, reg_waddr;           // muxed bus
    reg_data_t  reg_rdata, reg_wdata;
    logic       reg_wen, lreq, wdog_timeout;

    logic [87:0] stim_mem [0:31];
    stim_t       cur;
    int          seed = 32'h21a9_9a73;
    int          errors = 0;
    int          tests = 0;
    int          passed = 0;
    int          errs_before;

    fpga_board_core i_fpga_board_core (.*);

    always #4 sysclk = ~sysclk;                 // 8 ns period

    // ----------------------------------------
    // host bus tasks driven on the falling edge
    // ----------------------------------------
    task automatic clear_hosts();
        {fw_req_read_bus, fw_req_write_bus, fw_reg_wen, fw_lreq_trig} = '0;
        {eth_req_read_bus, eth_req_write_bus, eth_reg_wen, eth_lreq_trig} = '0;
        wdog_clear = 1'b0;
    endtask

    task automatic check_value(input string name, input reg_data_t exp, input reg_data_t got);
        assert (got === exp) else begin
            $display("ERR %s expected %h got %h", name, exp, got);
            errors++;
        end
    endtask

    // host 2 writes from both sides with fw carrying the inverted word
    task automatic host_write(input logic [3:0] host, input reg_addr_t addr, input reg_data_t data);
        @(negedge sysclk);
        clear_hosts();
        fw_reg_waddr      = addr;
        eth_reg_waddr     = addr;
        fw_reg_wdata      = (host == 4'd2) ? ~data : data;
        eth_reg_wdata     = data;
        fw_req_write_bus  = (host != 4'd1);
        fw_reg_wen        = (host != 4'd1);
        eth_req_write_bus = (host != 4'd0);
        eth_reg_wen       = (host != 4'd0);
        #2;                                     // muxed write bus settled
        check_value("reg_waddr", 32'(addr), 32'(reg_waddr));
        check_value("reg_wdata", data, reg_wdata);
        check_value("reg_wen", 32'd1, 32'(reg_wen));
        @(negedge sysclk);                      // write lands on the edge in between
        clear_hosts();
    endtask

    // host 2 reads from both sides with fw at the inverted address
    task automatic host_read(input logic [3:0] host, input reg_addr_t addr,
                             input reg_data_t ext, input reg_data_t exp);
        @(negedge sysclk);
        clear_hosts();
        fw_reg_raddr     = (host == 4'd2) ? ~addr : addr;
        eth_reg_raddr    = addr;
        fw_req_read_bus  = (host != 4'd1);
        eth_req_read_bus = (host != 4'd0);
        reg_rdata_ext    = ext;
        #2;                                     // mid low phase where rdata has settled
        check_value("reg_raddr", 32'(addr), 32'(reg_raddr));
        check_value("reg_rdata", exp, reg_rdata);
    endtask

    // ----------------------------------------
    // link request frame
    // ----------------------------------------
    task automatic send_lreq(input logic [3:0] host);
        lreq_type_t  rtype;
        lreq_data_t  payload;
        logic [15:0] frame;                     // bits after the start bit
        int          wait_cnt;
        rtype   = lreq_type_t'($random(seed));
        payload = lreq_data_t'($random(seed));
        frame   = {rtype, payload, 1'b0};       // type, data, stop
        @(negedge sysclk);
        clear_hosts();
        fw_lreq_type      = (host == 4'd0) ? rtype : ~rtype;   // idle host disagrees
        eth_lreq_type     = (host == 4'd0) ? ~rtype : rtype;
        fw_reg_wdata      = 32'((host == 4'd0) ? payload : ~payload);
        eth_reg_wdata     = 32'((host == 4'd0) ? ~payload : payload);
        fw_req_write_bus  = (host == 4'd0);
        eth_req_write_bus = (host != 4'd0);
        fw_lreq_trig      = (host == 4'd0);
        eth_lreq_trig     = (host != 4'd0);
        @(negedge sysclk);
        clear_hosts();
        wait_cnt = 0;
        while (!lreq && wait_cnt < 4) begin
            @(negedge sysclk);
            wait_cnt++;
        end
        assert (lreq) else begin
            $display("no lreq start bit within 4 cycles of the trigger from host %0d", host);
            errors++;
        end
        for (int i = 15; i >= 0 && lreq_started(wait_cnt); i--) begin
            @(negedge sysclk);
            fw_lreq_trig = (i == 10);           // mid-frame retrigger that must be dropped
            check_value("lreq", 32'(frame[i]), 32'(lreq));
        end
    endtask

    function automatic bit lreq_started(input int wait_cnt);
        return wait_cnt < 4;
    endfunction

    // ----------------------------------------
    // watchdog timeout, status bit, clear and keep-alive
    // ----------------------------------------
    task automatic run_watchdog(input reg_data_t period);
        int cyc;
        host_write(4'd1, reg_addr_t'(`REG_WDOG), period);
        cyc = 0;
        while (!wdog_timeout && cyc < 40) begin
            @(negedge sysclk);
            cyc++;
        end
        assert (wdog_timeout && cyc > 16) else begin
            $display("watchdog flag wrong, high=%0d after %0d cycles", wdog_timeout, cyc);
            errors++;
        end
        // board id in bits 27:24 and the timeout flag in bit 0
        host_read(4'd0, reg_addr_t'(`REG_STATUS), '0, (reg_data_t'(BOARD_NUM) << 24) | 32'd1);
        @(negedge sysclk);
        clear_hosts();
        wdog_clear       = 1'b1;
        fw_reg_waddr     = reg_addr_t'(`REG_STATUS);   // kick with the clear
        fw_req_write_bus = 1'b1;
        fw_reg_wen       = 1'b1;
        @(negedge sysclk);
        clear_hosts();
        check_value("wdog_timeout", '0, 32'(wdog_timeout));
        for (int k = 0; k < 80; k++) begin
            if (k % 20 == 19)
                host_write(4'd0, reg_addr_t'(`REG_STATUS), '0);    // keep-alive
            else
                @(negedge sysclk);
            check_value("wdog_timeout", '0, 32'(wdog_timeout));
        end
        host_write(4'd1, reg_addr_t'(`REG_WDOG), '0);  // watchdog off again
    endtask

    initial begin
        rst_n = 1'b0;
        clear_hosts();
        {fw_reg_raddr, fw_reg_waddr, eth_reg_raddr, eth_reg_waddr} = '0;
        {fw_reg_wdata, eth_reg_wdata, reg_rdata_ext} = '0;
        fw_lreq_type  = '0;
        eth_lreq_type = '0;
        board_id      = BOARD_NUM;
        $readmemh("test/stim_input.txt", stim_mem);
        repeat (2) @(negedge sysclk);           // two rising edges in reset
        rst_n = 1'b1;
        for (int t = 0; t < 32; t++) begin
            cur = stim_t'(stim_mem[t]);
            if (cur.op == 4'hf)
                break;
            errs_before = errors;
            case (cur.op)
                4'h1: host_write(cur.host, cur.addr, cur.data);
                4'h2: host_read(cur.host, cur.addr, cur.data, cur.exp);
                4'h3: send_lreq(cur.host);
                4'h4: run_watchdog(cur.data);
                default: begin
                    $display("unknown operation %h on stimulus line %0d", cur.op, t);
                    errors++;
                end
            endcase
            tests++;
            if (errors == errs_before)
                passed++;
            $display("test %0d op %h host %h: %s", t, cur.op, cur.host,
                     (errors == errs_before) ? "ok" : "FAIL");
        end
        assert (tests > 0) else begin
            $display("no stimulus lines were read");
            errors++;
        end
        $display("tests %0d, passed %0d, failed %0d", tests, passed, tests - passed);
        if (errors == 0)
            $display("sim passed");
        else
            $display("sim failed");
        $finish;
    end

endmodule

/* test/stim_input.txt */
// columns, all hex: op_host_addr_data_expected
// op 1 write, 2 read (data is the external read data), 3 link request, 4 watchdog (data is period)
// host 0 fw, 1 eth, 2 both (fw carries the inverted data or address), op f ends the list
2_0_000b_00000000_ffffffff  // ip address after reset
1_0_000b_c0a80a05_00000000  // fw writes ip
2_1_000b_00000000_c0a80a05  // eth reads it back
1_1_0003_00000100_00000000  // eth writes watchdog period
2_0_0003_00000000_00000100  // fw reads it back
1_2_000b_0a000001_00000000  // both write ip, eth wins
2_1_000b_00000000_0a000001
2_2_0003_12345678_00000100  // both read, eth address wins
2_0_4000_deadbeef_deadbeef  // other space goes external
2_1_0007_a5a5a5a5_a5a5a5a5  // unused main offset goes external
2_0_0000_00000000_09000000  // status with board id 9
3_0_0000_00000000_00000000  // link request from fw
3_1_0000_00000000_00000000  // link request from eth
4_1_0003_00000002_00000000  // watchdog with period 2
f_0_0000_00000000_00000000

/* fpga_board_core.f */
+incdir+logic
logic/regbus_pkg.sv
logic/phylink_pkg.sv
logic/host_bus_mux.sv
logic/board_regs.sv
logic/wdog_timer.sv
logic/phy_request.sv
logic/fpga_board_core.sv
test/fpga_board_core_sva.sv
test/tb_fpga_board_core.sv

/* Makefile */
# Verilator simulation of the host-bus core testbench
TOP := tb_fpga_board_core

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run, pass if the output has the pass message"
	@echo "  clean  remove the Verilator build directory"

test:
	verilator --binary --timing --assert -f fpga_board_core.f --top-module $(TOP) -Mdir obj_dir
	out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "^sim passed$$"

clean:
	rm -rf obj_dir
